/* Bender.yml */
package:
  name: accum_subsystem

export_include_dirs:
  - design

sources:
  - design/accumPkg.sv
  - design/sharedRam.sv
  - design/memArbiter.sv
  - design/cmdFifo.sv
  - design/accumPeer.sv
  - design/accumTop.sv
  - target: test
    files:
      - dv/accumTb.sv

/* design/accumPeer.sv */
////////////////////////////////////////
// one accumulator unit
// buffers command strobes, then does an
// atomic read-modify-write on the ram:
// read, add/sub/store with overflow,
// write back, registered result strobe
// minimum latency is 3 cycles
////////////////////////////////////////

`include "accum_macros.svh"

module accumPeer (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   cmdValid,     // single-cycle strobe
  input  accumPkg::accCmdT       cmd,
  output accumPkg::memReqT       memReq,
  input  logic                   grant,        // from the arbiter, combinational
  input  logic [`ACC_DATA_W-1:0] rdData,       // shared read bus
  output logic                   resultValid,  // single-cycle strobe
  output accumPkg::accResultT    result
);

  import accumPkg::*;

  localparam int dataW = `ACC_DATA_W;

  peerStateE        state;
  peerStateE        stateNext;
  accCmdT           head;        // command being serviced
  logic             empty;
  logic             inRead;
  logic             inWrite;
  logic             sub;
  logic [dataW-1:0] opnd;        // operand, inverted when subtracting
  logic [dataW-1:0] sum;
  logic             cSign;       // carry into the sign bit
  logic             cOut;        // carry out of the sign bit
  logic [dataW-1:0] newVal;
  logic             ovf;
  accResultT        resultD;

  cmdFifo uFifo (
    .clk      (clk),
    .arstN    (arstN),
    .push     (cmdValid),        // no back-pressure, always taken
    .pushData (cmd),
    .pop      (inWrite),         // head retires in the write cycle
    .head     (head),
    .empty    (empty)
  );

  assign inRead  = (state == stRead);
  assign inWrite = (state == stWrite);

  // sequencer
  always_comb begin
    stateNext = state;
    case (state)
      stIdle: begin
        if (cmdValid || !empty) begin
          stateNext = stRead;  // head is ready next cycle
        end
      end
      stRead: begin
        if (grant) begin
          stateNext = stWrite;  // read issued this cycle
        end
      end
      stWrite:  stateNext = stIdle;
      default:  stateNext = stIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stIdle;
    end else begin
      state <= stateNext;
    end
  end

  // add/sub, split at the sign bit so both carries are visible
  assign sub  = (head.op == opSub);
  assign opnd = head.operand ^ {dataW{sub}};  // plus carry-in gives two's complement
  assign {cSign, sum[dataW-2:0]} = {1'b0, rdData[dataW-2:0]}
                                 + {1'b0, opnd[dataW-2:0]}
                                 + {{(dataW-1){1'b0}}, sub};
  assign {cOut, sum[dataW-1]} = {1'b0, rdData[dataW-1]}
                              + {1'b0, opnd[dataW-1]}
                              + {1'b0, cSign};

  always_comb begin
    case (head.op)
      opStore: begin
        newVal = head.operand;
        ovf    = 1'b0;
      end
      opRead: begin
        newVal = rdData;  // word unchanged
        ovf    = 1'b0;
      end
      default: begin
        newVal = sum;
        ovf    = cSign ^ cOut;  // sign carries disagree
      end
    endcase
  end

  // ram request, lock during the read keeps the write cycle ours
  always_comb begin
    memReq.req    = inRead;
    memReq.lock   = inRead;
    memReq.rdAddr = head.addr;
    memReq.we     = inWrite && (head.op != opRead);
    memReq.wrAddr = head.addr;
    memReq.wrData = newVal;
  end

  always_comb begin
    resultD.op     = head.op;
    resultD.addr   = head.addr;
    resultD.oldVal = rdData;
    resultD.newVal = newVal;
    resultD.ovf    = ovf;
  end

  // result strobe one cycle after the write
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resultValid <= 1'b0;
    end else begin
      resultValid <= inWrite;
    end
  end

  always_ff @(posedge clk) begin
    if (inWrite) begin
      result <= resultD;  // payload held until the next access
    end
  end

endmodule

/* design/accumPkg.sv */
////////////////////////////////////////
// types shared by the accumulator
// subsystem: opcodes, peer states and
// the command, result and ram request
// structs
////////////////////////////////////////

`include "accum_macros.svh"

package accumPkg;

  // command opcode, 2 bits
  typedef enum logic [1:0] {
    opAdd,    // word + operand
    opSub,    // word - operand
    opRead,   // plain read, no write-back
    opStore   // overwrite word with operand
  } accOpE;

  // peer sequencer
  typedef enum logic [1:0] {
    stIdle,   // nothing pending
    stRead,   // head waiting for or doing its ram read
    stWrite   // rdData valid, compute and write back
  } peerStateE;

  // incoming command, 22 bits
  typedef struct packed {
    accOpE                  op;
    logic [`ACC_ADDR_W-1:0] addr;
    logic [`ACC_DATA_W-1:0] operand;
  } accCmdT;

  // outgoing result, 39 bits
  typedef struct packed {
    accOpE                  op;
    logic [`ACC_ADDR_W-1:0] addr;
    logic [`ACC_DATA_W-1:0] oldVal;  // word before the access
    logic [`ACC_DATA_W-1:0] newVal;  // word after the access
    logic                   ovf;     // signed overflow of add/sub
  } accResultT;

  // one peer's request towards the arbiter
  typedef struct packed {
    logic                   req;     // wants the ram
    logic                   lock;    // keep grant for the next cycle
    logic [`ACC_ADDR_W-1:0] rdAddr;
    logic                   we;
    logic [`ACC_ADDR_W-1:0] wrAddr;
    logic [`ACC_DATA_W-1:0] wrData;
  } memReqT;

endpackage

/* design/accumTop.sv */
////////////////////////////////////////
// accumulator subsystem top
// two peers share one ram through the
// rotating priority arbiter
// one command and one result port per
// peer, strobes only
////////////////////////////////////////

`include "accum_macros.svh"

module accumTop (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic [`ACC_NUM_PORTS-1:0] cmdValid,
  input  accumPkg::accCmdT          cmd [`ACC_NUM_PORTS],
  output logic [`ACC_NUM_PORTS-1:0] resultValid,
  output accumPkg::accResultT       result [`ACC_NUM_PORTS]
);

  import accumPkg::*;

  memReqT                    memReq [`ACC_NUM_PORTS];  // peer to arbiter
  logic [`ACC_NUM_PORTS-1:0] grant;
  logic                      we;
  logic [`ACC_ADDR_W-1:0]    wrAddr;
  logic [`ACC_DATA_W-1:0]    wrData;
  logic [`ACC_ADDR_W-1:0]    rdAddr;
  logic [`ACC_DATA_W-1:0]    rdData;                   // broadcast to all peers

  for (genvar i = 0; i < `ACC_NUM_PORTS; i++) begin : gPeer
    accumPeer uPeer (
      .clk         (clk),
      .arstN       (arstN),
      .cmdValid    (cmdValid[i]),
      .cmd         (cmd[i]),
      .memReq      (memReq[i]),
      .grant       (grant[i]),
      .rdData      (rdData),
      .resultValid (resultValid[i]),
      .result      (result[i])
    );
  end

  memArbiter uArb (
    .clk    (clk),
    .arstN  (arstN),
    .req    (memReq),
    .grant  (grant),
    .we     (we),
    .wrAddr (wrAddr),
    .wrData (wrData),
    .rdAddr (rdAddr)
  );

  sharedRam uRam (
    .clk    (clk),
    .we     (we),
    .wrAddr (wrAddr),
    .wrData (wrData),
    .rdAddr (rdAddr),
    .rdData (rdData)
  );

endmodule

/* design/accum_macros.svh */
////////////////////////////////////////
// width and size macros for the shared
// memory accumulator subsystem
// include in any file that sizes ports,
// memories or pointers
////////////////////////////////////////

`ifndef ACCUM_MACROS_SVH
`define ACCUM_MACROS_SVH

// ram word and operand width
`define ACC_DATA_W 16
// ram address width, 16 words
`define ACC_ADDR_W 4
// entries per command fifo
`define ACC_FIFO_DEPTH 4
// number of peer accumulator units
`define ACC_NUM_PORTS 2

`endif

/* design/cmdFifo.sv */
////////////////////////////////////////
// small command fifo for one peer
// circular buffer with a count, push
// and pop may share a cycle
// the caller's issue rate keeps it from
// filling, there is no full flag
////////////////////////////////////////

`include "accum_macros.svh"

module cmdFifo (
  input  logic             clk,
  input  logic             arstN,
  input  logic             push,
  input  accumPkg::accCmdT pushData,
  input  logic             pop,
  output accumPkg::accCmdT head,   // oldest entry, valid when not empty
  output logic             empty
);

  import accumPkg::*;

  localparam int ptrW = $clog2(`ACC_FIFO_DEPTH);

  accCmdT          mem [`ACC_FIFO_DEPTH];  // payload only, no reset
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   count;                  // 0 .. depth

  // step a pointer with wrap at the last entry
  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] p);
    nextPtr = (p == ptrW'(`ACC_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  assign head  = mem[rdPtr];
  assign empty = (count == '0);

endmodule

/* design/memArbiter.sv */
////////////////////////////////////////
// rotating priority arbiter for the
// shared ram
// a masked and an unmasked fixed
// priority stage pick the owner, lock
// holds it for the write cycle, and the
// owner's request is muxed to the ram
////////////////////////////////////////

`include "accum_macros.svh"

module memArbiter (
  input  logic                      clk,
  input  logic                      arstN,
  input  accumPkg::memReqT          req [`ACC_NUM_PORTS],
  output logic [`ACC_NUM_PORTS-1:0] grant,   // one-hot
  output logic                      we,
  output logic [`ACC_ADDR_W-1:0]    wrAddr,
  output logic [`ACC_DATA_W-1:0]    wrData,
  output logic [`ACC_ADDR_W-1:0]    rdAddr
);

  localparam int nPorts = `ACC_NUM_PORTS;

  logic [nPorts-1:0] reqVec;       // request bits pulled out of the structs
  logic [nPorts-1:0] lockVec;
  logic [nPorts-1:0] maskQ;        // peers above the last one served
  logic [nPorts-1:0] ownerQ;       // grant of the previous cycle
  logic              holdQ;        // owner locked, this is its write cycle
  logic [nPorts-1:0] maskedGrant;
  logic [nPorts-1:0] plainGrant;
  logic [nPorts-1:0] freeGrant;

  // carry chain, lowest index wins
  // carry passes up only past bits with no request
  function automatic logic [nPorts-1:0] fixedPri(input logic [nPorts-1:0] r);
    logic [nPorts-1:0] c;
    c[0] = 1'b1;
    for (int i = 1; i < nPorts; i++) begin
      c[i] = c[i-1] & ~r[i-1];
    end
    return r & c;
  endfunction

  always_comb begin
    for (int i = 0; i < nPorts; i++) begin
      reqVec[i]  = req[i].req;
      lockVec[i] = req[i].lock;
    end
  end

  assign maskedGrant = fixedPri(reqVec & maskQ);
  assign plainGrant  = fixedPri(reqVec);                      // wraps around to peer 0
  assign freeGrant   = (|maskedGrant) ? maskedGrant : plainGrant;
  assign grant       = holdQ ? ownerQ : freeGrant;             // owner keeps it while locked

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      holdQ  <= 1'b0;
      ownerQ <= '0;
      maskQ  <= '1;  // full mask, peer 0 first
    end else begin
      holdQ  <= |(grant & lockVec);
      ownerQ <= grant;
      if (holdQ) begin
        maskQ <= ~((ownerQ << 1) - 1'b1);  // access done, skip past the owner
      end
    end
  end

  // and-or mux of the granted request
  always_comb begin
    we     = 1'b0;
    wrAddr = '0;
    wrData = '0;
    rdAddr = '0;
    for (int i = 0; i < nPorts; i++) begin
      we     = we | (grant[i] & req[i].we);
      wrAddr = wrAddr | ({`ACC_ADDR_W{grant[i]}} & req[i].wrAddr);
      wrData = wrData | ({`ACC_DATA_W{grant[i]}} & req[i].wrData);
      rdAddr = rdAddr | ({`ACC_ADDR_W{grant[i]}} & req[i].rdAddr);
    end
  end

endmodule

/* design/sharedRam.sv */
////////////////////////////////////////
// one read, one write synchronous ram
// read data is registered, one cycle
// after the address
// contents load from mem_init.hex at
// time zero, reset leaves them alone
////////////////////////////////////////

`include "accum_macros.svh"

module sharedRam (
  input  logic                   clk,
  input  logic                   we,      // write strobe
  input  logic [`ACC_ADDR_W-1:0] wrAddr,
  input  logic [`ACC_DATA_W-1:0] wrData,
  input  logic [`ACC_ADDR_W-1:0] rdAddr,
  output logic [`ACC_DATA_W-1:0] rdData   // valid the cycle after rdAddr
);

  // storage array, one entry per address
  logic [`ACC_DATA_W-1:0] mem [2**`ACC_ADDR_W];

  initial begin
    $readmemh("mem_init.hex", mem);  // initial image, shared with the model
  end

  // write and read in the same edge
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wrAddr] <= wrData;
    end
    rdData <= mem[rdAddr];  // nonblocking, so a same-address read sees the old word
  end

endmodule

/* dv/accumTb.sv */
////////////////////////////////////////
// testbench for the accumulator top
// random commands on both ports from an
// xorshift source, every result checked
// against a reference memory model that
// loads the same image as the ram
////////////////////////////////////////

`include "accum_macros.svh"

module accumTb;

  import accumPkg::*;

  localparam int numCmds   = 2000;   // random commands over both ports
  localparam int minGap    = 4;      // cycles between commands on one port
  localparam int maxCycles = 20000;  // bound on the random phase
  localparam int drainMax  = 200;    // cycles allowed for results to come back
  localparam int msb       = `ACC_DATA_W - 1;

  logic                      clk;
  logic                      arstN;
  logic [`ACC_NUM_PORTS-1:0] cmdValid;
  accCmdT                    cmd [`ACC_NUM_PORTS];
  logic [`ACC_NUM_PORTS-1:0] resultValid;
  accResultT                 result [`ACC_NUM_PORTS];

  logic [`ACC_DATA_W-1:0] modelMem [2**`ACC_ADDR_W];  // reference copy of the ram
  accCmdT                 pendQ0 [$];                  // issued on port 0, not answered
  accCmdT                 pendQ1 [$];
  int                     issued [`ACC_NUM_PORTS];
  int                     returned [`ACC_NUM_PORTS];
  logic [31:0]            rngState;
  bit                     firstCmdSeen;                // no result allowed before this
  int                     monCycles;

  accumTop u_dut (
    .clk         (clk),
    .arstN       (arstN),
    .cmdValid    (cmdValid),
    .cmd         (cmd),
    .resultValid (resultValid),
    .result      (result)
  );

  always #5 clk = ~clk;

  // 32 bit xorshift with shift amounts 13, 17 and 5
  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = rngState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rngState = x;
    return x;
  endfunction

  // mostly addresses 0..3 so both peers hit the same words
  function automatic accCmdT randomCmd();
    accCmdT      c;
    logic [31:0] r;
    r         = nextRand();
    c.op      = accOpE'(r[1:0]);
    c.addr    = (r[7:4] == 4'h0) ? r[11:8] : {2'b00, r[9:8]};
    c.operand = r[31:16];
    return c;
  endfunction

  task automatic reportMismatch(input string what, input int port,
                                input logic [31:0] expVal, input logic [31:0] gotVal);
    $display("Error: time %0t, port %0d %s mismatch, expected %h, got %h",
             $time, port, what, expVal, gotVal);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic reportFailure(input string what);
    $display("%s (time %0t)", what, $time);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  // drive one strobe and remember it for the result check
  task automatic sendCmd(input int p, input accCmdT c);
    cmdValid[p] <= 1'b1;
    cmd[p]      <= c;
    if (p == 0) begin
      pendQ0.push_back(c);
    end else begin
      pendQ1.push_back(c);
    end
    issued[p]++;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      cmdValid <= '0;
    end
  endtask

  function automatic bit allReturned();
    bit done;
    done = 1'b1;
    for (int p = 0; p < `ACC_NUM_PORTS; p++) begin
      if (returned[p] != issued[p]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  // results arrive in ram access order, so the model word is the old value
  task automatic checkResult(input int p, input accResultT r);
    accCmdT                 c;
    logic [`ACC_DATA_W-1:0] oldWord;
    logic [`ACC_DATA_W-1:0] expNew;
    logic                   expOvf;
    logic                   effSign;   // operand sign as seen by the adder
    bit                     haveCmd;
    haveCmd = (p == 0) ? (pendQ0.size() != 0) : (pendQ1.size() != 0);
    assert (haveCmd) else reportFailure($sformatf(
      "port %0d returned a result with no command outstanding", p));
    if (p == 0) begin
      c = pendQ0.pop_front();
    end else begin
      c = pendQ1.pop_front();
    end
    oldWord = modelMem[c.addr];
    expOvf  = 1'b0;
    case (c.op)
      opAdd: begin
        expNew  = oldWord + c.operand;
        effSign = c.operand[msb];
        expOvf  = (oldWord[msb] == effSign) && (expNew[msb] != oldWord[msb]);
      end
      opSub: begin
        expNew  = oldWord - c.operand;
        effSign = ~c.operand[msb];  // negated operand
        expOvf  = (oldWord[msb] == effSign) && (expNew[msb] != oldWord[msb]);
      end
      opRead: begin
        expNew = oldWord;
      end
      default: begin
        expNew = c.operand;  // store
      end
    endcase
    assert (r.op == c.op) else reportMismatch("opcode", p, 32'(c.op), 32'(r.op));
    assert (r.addr == c.addr) else reportMismatch("address", p, 32'(c.addr), 32'(r.addr));
    assert (r.oldVal == oldWord) else reportMismatch("old value", p, 32'(oldWord),
                                                      32'(r.oldVal));
    assert (r.newVal == expNew) else reportMismatch("new value", p, 32'(expNew),
                                                     32'(r.newVal));
    assert (r.ovf == expOvf) else reportMismatch("overflow", p, 32'(expOvf), 32'(r.ovf));
    if (c.op != opRead) begin
      modelMem[c.addr] = expNew;
    end
    returned[p]++;
  endtask

  // result monitor on the edge where the registered outputs are settled
  always @(posedge clk) begin
    if (monCycles > 0) begin
      if (!firstCmdSeen) begin
        assert (resultValid == '0) else reportFailure(
          "result strobe seen during reset or before any command");
      end
      assert (!(resultValid[0] && resultValid[1])) else reportFailure(
        "both ports returned a result in the same cycle");
    end
    if (cmdValid != '0) begin
      firstCmdSeen = 1'b1;  // strobe taken by the DUT on this edge
    end
    for (int p = 0; p < `ACC_NUM_PORTS; p++) begin
      if (resultValid[p] === 1'b1) begin
        checkResult(p, result[p]);
      end
    end
    monCycles++;
  end

  task automatic runRandom();
    int          total;
    int          cyc;
    int          lastIssue [`ACC_NUM_PORTS];
    logic [31:0] r;
    total = 0;
    cyc   = 0;
    for (int p = 0; p < `ACC_NUM_PORTS; p++) begin
      lastIssue[p] = -minGap;
    end
    while (total < numCmds) begin
      @(posedge clk);
      cmdValid <= '0;  // strobes last one cycle
      cyc++;
      if (cyc > maxCycles) begin
        reportFailure("timeout, random phase did not issue all commands");
      end
      for (int p = 0; p < `ACC_NUM_PORTS; p++) begin
        r = nextRand();
        if (r[0] && total < numCmds && (cyc - lastIssue[p]) >= minGap) begin
          sendCmd(p, randomCmd());
          lastIssue[p] = cyc;
          total++;
        end
      end
    end
  endtask

  task automatic drainResults(input string phase);
    int waited;
    waited = 0;
    while (!allReturned()) begin
      @(posedge clk);
      cmdValid <= '0;
      waited++;
      if (waited > drainMax) begin
        reportFailure($sformatf("timeout, results of the %s missing after %0d cycles",
                                phase, drainMax));
      end
    end
  endtask

  // read every word once through port 0
  task automatic readBackAll();
    accCmdT c;
    for (int a = 0; a < 2**`ACC_ADDR_W; a++) begin
      @(posedge clk);
      c.op      = opRead;
      c.addr    = `ACC_ADDR_W'(a);
      c.operand = '0;
      sendCmd(0, c);
      idleCycles(minGap - 1);
    end
  endtask

  initial begin
    clk          = 1'b0;
    arstN        = 1'b0;  // reset from time zero
    cmdValid     = '0;
    rngState     = 32'd69948;
    firstCmdSeen = 1'b0;
    monCycles    = 0;
    for (int p = 0; p < `ACC_NUM_PORTS; p++) begin
      cmd[p]      = '0;
      issued[p]   = 0;
      returned[p] = 0;
    end
    $readmemh("mem_init.hex", modelMem);
    repeat (16) @(posedge clk);
    arstN <= 1'b1;
    runRandom();
    drainResults("random phase");
    readBackAll();
    drainResults("final read-back");
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* mem_init.hex */
// one 16-bit ram word per line in hex, addresses 0 to 15 in order
0000
0001
7ffe
8001
1234
fff0
4000
c000
00ff
ff00
7fff
8000
0a5a
5a5a
a5a5
3c3c

/* sources.f */
+incdir+design
design/accumPkg.sv
design/sharedRam.sv
design/memArbiter.sv
design/cmdFifo.sv
design/accumPeer.sv
design/accumTop.sv
dv/accumTb.sv
